//--- common/io_bus_pkg.sv
package io_bus_pkg;

  typedef logic [16:0] adr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  sel_t;

  // peripheral selector, address bits 16 to 12
  typedef logic [4:0]  slot_t;

  localparam slot_t SLOT_LOCAL = 5'd0;  // segment word and fan register
  localparam slot_t SLOT_SWLED = 5'd1;  // switches in, LEDs out
  localparam slot_t SLOT_TIMER = 5'd8;

  // master side request, held until ack
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    sel_t  sel;
    adr_t  adr;
    data_t dat;
  } io_req_t;

  typedef struct packed {
    data_t dat;
    logic  ack;
  } io_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } access_state_t;

endpackage

//--- common/periph_pkg.sv
package periph_pkg;

  typedef logic [8:0]  led_t;
  typedef logic [15:0] sw_t;
  typedef logic [6:0]  seg_pattern_t;  // active low, segment a in bit 0
  typedef logic [7:0]  duty_t;
  typedef logic [31:0] count_t;

  // timer register index, address bits 5 to 2
  typedef logic [3:0]  treg_t;

  localparam treg_t TREG_RELOAD0 = 4'd0;
  localparam treg_t TREG_RELOAD1 = 4'd1;
  localparam treg_t TREG_RELOAD2 = 4'd2;
  localparam treg_t TREG_RELOAD3 = 4'd3;
  localparam treg_t TREG_CTRL    = 4'd4;  // one enable bit per channel
  localparam treg_t TREG_STATUS  = 4'd5;  // pending bits, write one to clear
  localparam treg_t TREG_COUNT0  = 4'd8;
  localparam treg_t TREG_COUNT1  = 4'd9;
  localparam treg_t TREG_COUNT2  = 4'd10;
  localparam treg_t TREG_COUNT3  = 4'd11;

  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    treg_t             adr;
    io_bus_pkg::data_t dat;
  } timer_req_t;

  localparam duty_t FAN_RESET_DUTY = 8'd128;

endpackage

//--- design/timer/timer_int.sv
module timer_int #(
  parameter int NUM_TIMERS = 4,
  parameter int TICK_DIV   = 1
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  periph_pkg::timer_req_t req_i,
  output io_bus_pkg::data_t      dat_o,
  output logic                   ack_o,
  output logic [NUM_TIMERS-1:0]  irq_o
);
  import io_bus_pkg::*;
  import periph_pkg::*;

  localparam int PW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
  localparam treg_t RELOAD_IDX [4] = '{TREG_RELOAD0, TREG_RELOAD1, TREG_RELOAD2, TREG_RELOAD3};
  localparam treg_t COUNT_IDX  [4] = '{TREG_COUNT0, TREG_COUNT1, TREG_COUNT2, TREG_COUNT3};

  logic [PW-1:0]         presc;
  logic                  tick;
  count_t                reload [NUM_TIMERS];
  count_t                count  [NUM_TIMERS];
  logic [NUM_TIMERS-1:0] enable, pending, expire;
  logic                  hit, wr;
  data_t                 rd_dat;

  assign hit  = req_i.cyc && req_i.stb;
  assign wr   = hit && req_i.we && ack_o;  // lands on the edge that ends the ack cycle
  assign tick = (presc == PW'(TICK_DIV - 1));

  always_comb begin
    for (int i = 0; i < NUM_TIMERS; i++)
      expire[i] = enable[i] && tick && (count[i] == '0);
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ack_o   <= 1'b0;
      presc   <= '0;
      enable  <= '0;
      pending <= '0;
      for (int i = 0; i < NUM_TIMERS; i++) begin
        reload[i] <= '0;
        count[i]  <= '0;
      end
    end else begin
      ack_o <= hit && !ack_o;
      presc <= tick ? '0 : presc + 1'b1;
      if (wr && req_i.adr == TREG_CTRL)
        enable <= req_i.dat[NUM_TIMERS-1:0];
      // a new expiry wins over a clear
      if (wr && req_i.adr == TREG_STATUS)
        pending <= (pending & ~req_i.dat[NUM_TIMERS-1:0]) | expire;
      else
        pending <= pending | expire;
      for (int i = 0; i < NUM_TIMERS; i++) begin
        if (wr && req_i.adr == RELOAD_IDX[i]) begin
          reload[i] <= req_i.dat;
          count[i]  <= req_i.dat;
        end else if (enable[i] && tick) begin
          count[i] <= expire[i] ? reload[i] : count[i] - 1'b1;
        end
      end
    end
  end

  always_comb begin
    rd_dat = '0;
    if (req_i.adr == TREG_CTRL)
      rd_dat = data_t'(enable);
    if (req_i.adr == TREG_STATUS)
      rd_dat = data_t'(pending);
    for (int i = 0; i < NUM_TIMERS; i++) begin
      if (req_i.adr == RELOAD_IDX[i])
        rd_dat = reload[i];
      if (req_i.adr == COUNT_IDX[i])
        rd_dat = count[i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (hit && !ack_o)
      dat_o <= rd_dat;
  end

  assign irq_o = pending;

  // the request stays up through the ack cycle where writes land
  ack_with_req: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_o |-> hit);

endmodule

//--- design/fan_pwm.sv
module fan_pwm (
  input  logic              clk_i,
  input  logic              rst_i,
  input  periph_pkg::duty_t duty_i,
  output logic              fan_o
);
  import periph_pkg::*;

  duty_t cnt;  // wraps every 256 cycles

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt   <= '0;
      fan_o <= 1'b0;
    end else begin
      cnt   <= cnt + 1'b1;
      fan_o <= (cnt < duty_i);  // duty 0 never high
    end
  end

endmodule

//--- design/seg_digits.sv
module seg_digits (
  input  io_bus_pkg::data_t              word_i,
  output periph_pkg::seg_pattern_t [7:0] hex_o
);
  import periph_pkg::*;

  function automatic seg_pattern_t to_seg(input logic [3:0] nib);
    case (nib)
      4'h0: to_seg = ~7'h3f;
      4'h1: to_seg = ~7'h06;
      4'h2: to_seg = ~7'h5b;
      4'h3: to_seg = ~7'h4f;
      4'h4: to_seg = ~7'h66;
      4'h5: to_seg = ~7'h6d;
      4'h6: to_seg = ~7'h7d;
      4'h7: to_seg = ~7'h07;
      4'h8: to_seg = ~7'h7f;
      4'h9: to_seg = ~7'h6f;
      4'ha: to_seg = ~7'h77;
      4'hb: to_seg = ~7'h7c;  // lower case b
      4'hc: to_seg = ~7'h39;
      4'hd: to_seg = ~7'h5e;  // lower case d
      4'he: to_seg = ~7'h79;
      default: to_seg = ~7'h71;
    endcase
  endfunction

  // digit 0 from the low nibble
  always_comb begin
    for (int i = 0; i < 8; i++)
      hex_o[i] = to_seg(word_i[4*i +: 4]);
  end

endmodule

//--- design/io_controller.sv
module io_controller (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  io_bus_pkg::io_req_t    req_i,
  output io_bus_pkg::io_rsp_t    rsp_o,
  input  periph_pkg::sw_t        sw_i,
  output periph_pkg::led_t       leds_o,
  output io_bus_pkg::data_t      seg_word_o,
  output periph_pkg::duty_t      fan_duty_o,
  output periph_pkg::timer_req_t timer_req_o,
  input  io_bus_pkg::data_t      timer_dat_i,
  input  logic                   timer_ack_i
);
  import io_bus_pkg::*;
  import periph_pkg::*;

  access_state_t state, state_next;
  data_t         seg_reg, seg_next;
  data_t         fan_reg, fan_next;
  led_t          led_reg, led_next;
  data_t         result, result_next;
  slot_t         slot;

  assign slot = req_i.adr[16:12];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state   <= IDLE;
      seg_reg <= '0;
      fan_reg <= data_t'(FAN_RESET_DUTY);
      led_reg <= '0;
    end else begin
      state   <= state_next;
      seg_reg <= seg_next;
      fan_reg <= fan_next;
      led_reg <= led_next;
    end
  end

  always_ff @(posedge clk_i) begin
    result <= result_next;  // read data held through DONE
  end

  always_comb begin
    state_next  = state;
    seg_next    = seg_reg;
    fan_next    = fan_reg;
    led_next    = led_reg;
    result_next = result;
    case (state)
      IDLE: begin
        if (req_i.cyc && req_i.stb)
          state_next = BUSY;
      end
      BUSY: begin
        case (slot)
          SLOT_LOCAL: begin
            if (req_i.we) begin
              if (req_i.adr[0])
                fan_next = req_i.dat;
              else
                seg_next = req_i.dat;
            end else begin
              result_next = req_i.adr[0] ? fan_reg : seg_reg;
            end
            state_next = DONE;
          end
          SLOT_SWLED: begin
            if (req_i.we)
              led_next = req_i.dat[8:0];
            else
              result_next = data_t'(sw_i);
            state_next = DONE;
          end
          SLOT_TIMER: begin
            // wait here until the timer answers
            if (timer_ack_i) begin
              result_next = timer_dat_i;
              state_next  = DONE;
            end
          end
          default: begin
            result_next = '0;  // unmapped
            state_next  = DONE;
          end
        endcase
      end
      DONE: state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  assign rsp_o.dat = result;
  assign rsp_o.ack = (state == DONE);

  assign timer_req_o.cyc = (state == BUSY);
  assign timer_req_o.stb = (slot == SLOT_TIMER);
  assign timer_req_o.we  = req_i.we;
  assign timer_req_o.adr = req_i.adr[5:2];
  assign timer_req_o.dat = req_i.dat;

  assign seg_word_o = seg_reg;
  assign fan_duty_o = fan_reg[7:0];  // only the low byte drives the fan
  assign leds_o     = led_reg;

  // a stuck timer ack would finish the next timer access early
  timer_ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
    timer_ack_i |=> !timer_ack_i);

endmodule

//--- design/io_top.sv
module io_top #(
  parameter int NUM_TIMERS = 4,
  parameter int TICK_DIV   = 1
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  io_bus_pkg::io_req_t            bus_req_i,
  output io_bus_pkg::io_rsp_t            bus_rsp_o,
  input  periph_pkg::sw_t                sw_i,
  output periph_pkg::led_t               leds_o,
  output logic                           fan_o,
  output periph_pkg::seg_pattern_t [7:0] hex_o,
  output logic [NUM_TIMERS-1:0]          irq_o
);
  import io_bus_pkg::*;
  import periph_pkg::*;

  timer_req_t timer_req;
  data_t      timer_dat;
  logic       timer_ack;
  data_t      seg_word;
  duty_t      fan_duty;

  io_controller io_controller_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (bus_req_i),
    .rsp_o       (bus_rsp_o),
    .sw_i        (sw_i),
    .leds_o      (leds_o),
    .seg_word_o  (seg_word),
    .fan_duty_o  (fan_duty),
    .timer_req_o (timer_req),
    .timer_dat_i (timer_dat),
    .timer_ack_i (timer_ack)
  );

  timer_int #(
    .NUM_TIMERS (NUM_TIMERS),
    .TICK_DIV   (TICK_DIV)
  ) timer_int_inst (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (timer_req),
    .dat_o (timer_dat),
    .ack_o (timer_ack),
    .irq_o (irq_o)
  );

  fan_pwm fan_pwm_inst (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .duty_i (fan_duty),
    .fan_o  (fan_o)
  );

  seg_digits seg_digits_inst (
    .word_i (seg_word),
    .hex_o  (hex_o)
  );

endmodule

//--- tb/tb_io_top.sv
module tb_io_top;
  timeunit 1ns;
  timeprecision 1ps;

  import io_bus_pkg::*;
  import periph_pkg::*;

  localparam adr_t SEG_ADR   = 17'h00000;
  localparam adr_t FAN_ADR   = 17'h00001;
  localparam adr_t SWLED_ADR = 17'h01000;
  localparam adr_t TIMER_ADR = 17'h08000;
  localparam adr_t NOMAP_ADR = 17'h02000;  // former uart slot

  // lit segments per hex digit with segment a in bit 0
  localparam logic [6:0] LIT [16] = '{
    7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
    7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

  logic               clk = 1'b0;
  logic               rst;
  io_req_t            bus_req;
  io_rsp_t            bus_rsp;
  sw_t                sw;
  led_t               leds;
  logic               fan;
  seg_pattern_t [7:0] hex;
  logic [3:0]         irq;
  integer             seed = 14;
  int                 mismatches = 0;
  int                 timeouts = 0;

  io_top #(
    .NUM_TIMERS (4),
    .TICK_DIV   (1)
  ) io_top_inst (
    .clk_i     (clk),
    .rst_i     (rst),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .sw_i      (sw),
    .leds_o    (leds),
    .fan_o     (fan),
    .hex_o     (hex),
    .irq_o     (irq)
  );

  always #20 clk = ~clk;

  function automatic seg_pattern_t expected_seg(input logic [3:0] nib);
    return ~LIT[nib];  // active low
  endfunction

  function automatic adr_t timer_adr(input treg_t idx);
    return TIMER_ADR | adr_t'({idx, 2'b00});
  endfunction

  task automatic compare(input string what, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_at_most(input string what, input data_t got, input data_t limit);
    if (got > limit) begin
      $display("Mismatch at %0t ns: %s is %0d, above %0d", $time, what, got, limit);
      mismatches++;
    end
  endtask

  task automatic check_hex(input data_t word);
    for (int i = 0; i < 8; i++)
      compare($sformatf("hex digit %0d", i), data_t'(hex[i]),
              data_t'(expected_seg(word[4*i +: 4])));
  endtask

  task automatic bus_access(input logic we, input adr_t adr, input data_t wdat,
                            output data_t rdat);
    int n;
    @(negedge clk);
    bus_req.cyc = 1'b1;
    bus_req.stb = 1'b1;
    bus_req.we  = we;
    bus_req.sel = 4'hf;
    bus_req.adr = adr;
    bus_req.dat = wdat;
    n = 0;
    @(negedge clk);
    while (!bus_rsp.ack && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!bus_rsp.ack) begin
      $display("Timeout at %0t ns: no ack for address %h within 20 cycles", $time, adr);
      timeouts++;
    end
    rdat = bus_rsp.dat;
    bus_req.cyc = 1'b0;
    bus_req.stb = 1'b0;
    bus_req.we  = 1'b0;
  endtask

  task automatic bus_write(input adr_t adr, input data_t dat);
    data_t unused;
    bus_access(1'b1, adr, dat, unused);
  endtask

  task automatic bus_read(input adr_t adr, output data_t dat);
    bus_access(1'b0, adr, '0, dat);
  endtask

  task automatic wait_irq(input int idx);
    int n;
    n = 0;
    while (!irq[idx] && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (!irq[idx]) begin
      $display("Timeout at %0t ns: irq bit %0d never rose", $time, idx);
      timeouts++;
    end
  endtask

  task automatic test_reset();
    data_t rd;
    compare("leds after reset", data_t'(leds), '0);
    compare("irq after reset", data_t'(irq), '0);
    check_hex(32'h0);
    bus_read(FAN_ADR, rd);
    compare("fan register after reset", rd, data_t'(FAN_RESET_DUTY));
  endtask

  task automatic test_local();
    data_t rd;
    int    highs;
    bus_write(SEG_ADR, 32'h3a5f_c190);
    check_hex(32'h3a5f_c190);
    bus_read(SEG_ADR, rd);
    compare("segment register", rd, 32'h3a5f_c190);
    bus_write(FAN_ADR, 32'd60);
    bus_read(FAN_ADR, rd);
    compare("fan register", rd, 32'd60);
    repeat (2) @(negedge clk);  // fan output is registered
    highs = 0;
    repeat (256) begin
      @(negedge clk);
      if (fan)
        highs++;
    end
    compare("fan high cycles per period", data_t'(highs), 32'd60);
  endtask

  task automatic test_swled();
    data_t rd;
    repeat (3) begin
      @(negedge clk);
      sw = sw_t'($random(seed));
      bus_read(SWLED_ADR, rd);
      compare("switch read-back", rd, {16'h0, sw});
    end
    bus_write(SWLED_ADR, 32'hffff_fd5a);
    compare("leds", data_t'(leds), 32'h15a);  // upper bits dropped
  endtask

  task automatic test_timer();
    data_t rd;
    bus_write(timer_adr(TREG_RELOAD0), 32'd5);
    bus_write(timer_adr(TREG_RELOAD1), 32'd9);
    bus_write(timer_adr(TREG_RELOAD2), 32'd77);  // left disabled
    bus_write(timer_adr(TREG_CTRL), 32'h3);
    wait_irq(0);
    wait_irq(1);
    bus_read(timer_adr(TREG_COUNT0), rd);
    check_at_most("count of channel 0", rd, 32'd5);
    bus_read(timer_adr(TREG_COUNT1), rd);
    check_at_most("count of channel 1", rd, 32'd9);
    bus_read(timer_adr(TREG_COUNT2), rd);
    compare("count of disabled channel 2", rd, 32'd77);
    bus_write(timer_adr(TREG_CTRL), 32'h0);  // stop so no new expiry races the clear
    bus_read(timer_adr(TREG_STATUS), rd);
    compare("timer status", rd, 32'h3);
    compare("irq with two channels pending", data_t'(irq), 32'h3);
    bus_write(timer_adr(TREG_STATUS), 32'h1);
    compare("irq after clearing bit 0", data_t'(irq), 32'h2);
    bus_write(timer_adr(TREG_STATUS), 32'h2);
    compare("irq after clearing bit 1", data_t'(irq), 32'h0);
  endtask

  task automatic test_unmapped();
    data_t rd;
    bus_read(NOMAP_ADR, rd);
    compare("unmapped read", rd, '0);
    bus_write(NOMAP_ADR, 32'hffff_ffff);
    compare("leds after unmapped write", data_t'(leds), 32'h15a);
    check_hex(32'h3a5f_c190);
    bus_read(FAN_ADR, rd);
    compare("fan register after unmapped write", rd, 32'd60);
  endtask

  initial begin
    rst = 1'b1;
    bus_req = '0;
    sw = '0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    test_reset();
    test_local();
    test_swled();
    test_timer();
    test_unmapped();
    $display("error count: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches + timeouts == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

//--- build.f
common/io_bus_pkg.sv
common/periph_pkg.sv
design/timer/timer_int.sv
design/fan_pwm.sv
design/seg_digits.sv
design/io_controller.sv
design/io_top.sv
tb/tb_io_top.sv

//--- Bender.yml
package:
  name: io_top

sources:
  - common/io_bus_pkg.sv
  - common/periph_pkg.sv
  - design/timer/timer_int.sv
  - design/fan_pwm.sv
  - design/seg_digits.sv
  - design/io_controller.sv
  - design/io_top.sv
  - target: test
    files:
      - tb/tb_io_top.sv
